// ==== rtl/capi_read_pkg.sv ====
`default_nettype none

package capi_read_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////////////////////

  localparam int TAG_BITS          = 8;
  localparam int TAG_COUNT         = 16;                 // Low tag bits index the table
  localparam int TAG_INDEX_BITS    = $clog2(TAG_COUNT);
  localparam int DW_COUNT          = 8;                  // Double words per half line
  localparam int DW_BITS           = 64;
  localparam int HALF_LINE_BITS    = DW_COUNT * DW_BITS; // 512
  localparam int LINE_BITS         = 2 * HALF_LINE_BITS;
  localparam int ITEM_COUNT_BITS   = 32;
  localparam int ADDRESS_BITS      = 64;
  localparam int WED_RESERVED_BITS = HALF_LINE_BITS - ITEM_COUNT_BITS - 2 * ADDRESS_BITS;

  ////////////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    CMD_NONE = 2'b00,
    CMD_READ = 2'b01,
    CMD_WED  = 2'b10
  } cmd_type_t;

  // Lookup result that travels with a routed half
  typedef struct packed {
    logic [TAG_BITS-1:0] tag;
    cmd_type_t           cmd_type;
  } tag_entry_t;

  // Work element descriptor layout with the item count in the top bits
  typedef struct packed {
    logic [ITEM_COUNT_BITS-1:0]   item_count;
    logic [ADDRESS_BITS-1:0]      source_address;
    logic [ADDRESS_BITS-1:0]      destination_address;
    logic [WED_RESERVED_BITS-1:0] reserved;
  } wed_fields_t;

  typedef union packed {
    logic [HALF_LINE_BITS-1:0] raw;
    wed_fields_t               wed;
  } half_line_u;

endpackage

`default_nettype wire

// ==== rtl/buffer_write_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// One beat of the host buffer write
interface buffer_write_if;
  import capi_read_pkg::*;

  logic                write_valid;
  logic [TAG_BITS-1:0] write_tag;
  logic                write_tag_parity; // Odd parity over the tag
  logic                write_address;    // 0 low half, 1 high half
  half_line_u          write_data;
  logic [DW_COUNT-1:0] write_parity;     // One bit per double word

  modport receive (
    input write_valid, write_tag, write_tag_parity, write_address, write_data, write_parity
  );

endinterface

`default_nettype wire

// ==== rtl/data_control_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// Routed output for one half line
interface data_control_if;
  import capi_read_pkg::*;

  logic       valid;
  logic       read_data; // Half belongs to a read line
  logic       wed_data;  // Half holds a WED
  tag_entry_t cmd;
  half_line_u data;

  modport source (
    output valid, read_data, wed_data, cmd, data
  );

  modport receive (
    input valid, read_data, wed_data, cmd, data
  );

endinterface

`default_nettype wire

// ==== rtl/command_tag_table.sv ====
`timescale 1ns/100ps
`default_nettype none

module command_tag_table (
  input  logic                                 clock,
  input  logic                                 rstn,
  input  logic                                 issue_valid,
  input  logic [capi_read_pkg::TAG_BITS-1:0]   issue_tag,
  input  capi_read_pkg::cmd_type_t             issue_type,
  input  logic [capi_read_pkg::TAG_BITS-1:0]   lookup_tag,
  output capi_read_pkg::tag_entry_t            lookup_entry
);
  import capi_read_pkg::*;

  tag_entry_t                entries [TAG_COUNT];
  logic [TAG_INDEX_BITS-1:0] issue_index;
  logic [TAG_INDEX_BITS-1:0] lookup_index;

  assign issue_index  = issue_tag[TAG_INDEX_BITS-1:0];
  assign lookup_index = lookup_tag[TAG_INDEX_BITS-1:0];

  // Full tag is kept so aliasing tags miss
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      for (int i = 0; i < TAG_COUNT; i++) begin
        entries[i] <= '{tag: '0, cmd_type: CMD_NONE};
      end
    end else if (issue_valid) begin
      entries[issue_index] <= '{tag: issue_tag, cmd_type: issue_type};
    end
  end

  // Asynchronous lookup for the latched beat
  always_comb begin
    lookup_entry.tag = lookup_tag;
    if (entries[lookup_index].tag == lookup_tag) begin
      lookup_entry.cmd_type = entries[lookup_index].cmd_type;
    end else begin
      lookup_entry.cmd_type = CMD_NONE; // Never issued
    end
  end

endmodule

`default_nettype wire

// ==== rtl/buffer_parity_check.sv ====
`timescale 1ns/100ps
`default_nettype none

module buffer_parity_check (
  input  logic                  clock,
  input  logic                  rstn,
  input  logic                  enabled,
  buffer_write_if.receive       buffer,
  output logic [1:0]            data_read_error // Bit 0 tag, bit 1 data
);
  import capi_read_pkg::*;

  logic                valid_latched;
  logic [TAG_BITS-1:0] tag_latched;
  logic                tag_parity_latched;
  half_line_u          data_latched;
  logic [DW_COUNT-1:0] parity_latched;
  logic                tag_error;
  logic [DW_COUNT-1:0] dw_error;
  logic [1:0]          error_flags;

  // Input stage
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      valid_latched <= 1'b0;
    end else begin
      valid_latched <= enabled & buffer.write_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (enabled && buffer.write_valid) begin
      tag_latched        <= buffer.write_tag;
      tag_parity_latched <= buffer.write_tag_parity;
      data_latched       <= buffer.write_data;
      parity_latched     <= buffer.write_parity;
    end
  end

  // Odd parity holds when data plus parity bit has an odd count of ones
  always_comb begin
    tag_error = ~(^{tag_latched, tag_parity_latched});
    for (int i = 0; i < DW_COUNT; i++) begin
      dw_error[i] = ~(^{data_latched.raw[i*DW_BITS +: DW_BITS], parity_latched[i]});
    end
  end

  // Flag register, then output register
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      error_flags     <= 2'b00;
      data_read_error <= 2'b00;
    end else begin
      error_flags     <= valid_latched ? {|dw_error, tag_error} : 2'b00;
      data_read_error <= error_flags;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/read_data_control.sv ====
`timescale 1ns/100ps
`default_nettype none

module read_data_control (
  input  logic                               clock,
  input  logic                               rstn,
  input  logic                               enabled_in,
  buffer_write_if.receive                    buffer,
  output logic [capi_read_pkg::TAG_BITS-1:0] lookup_tag,
  input  capi_read_pkg::tag_entry_t          lookup_entry,
  output logic                               enabled,
  data_control_if.source                     half_low,
  data_control_if.source                     half_high
);
  import capi_read_pkg::*;

  logic                valid_latched;
  logic [TAG_BITS-1:0] tag_latched;
  logic                address_latched;
  half_line_u          data_latched;
  logic                low_select;
  logic                high_select;
  logic                is_read;
  logic                is_wed;

////////////////////////////////////////////////////////////////////////////
// Enable register
////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      enabled <= 1'b0;
    end else begin
      enabled <= enabled_in;
    end
  end

////////////////////////////////////////////////////////////////////////////
// Input latch
////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      valid_latched <= 1'b0;
    end else begin
      valid_latched <= enabled & buffer.write_valid; // Nothing taken while disabled
    end
  end

  always_ff @(posedge clock) begin
    if (enabled && buffer.write_valid) begin
      tag_latched     <= buffer.write_tag;
      address_latched <= buffer.write_address;
      data_latched    <= buffer.write_data;
    end
  end

  assign lookup_tag = tag_latched; // Table answers in the same cycle

////////////////////////////////////////////////////////////////////////////
// Command decode and half routing
////////////////////////////////////////////////////////////////////////////

  assign low_select  = valid_latched & ~address_latched;
  assign high_select = valid_latched & address_latched;
  assign is_read     = (lookup_entry.cmd_type == CMD_READ);
  assign is_wed      = (lookup_entry.cmd_type == CMD_WED);

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      half_low.valid      <= 1'b0;
      half_low.read_data  <= 1'b0;
      half_low.wed_data   <= 1'b0;
      half_high.valid     <= 1'b0;
      half_high.read_data <= 1'b0;
      half_high.wed_data  <= 1'b0;
    end else begin
      half_low.valid      <= low_select;
      half_low.read_data  <= low_select & is_read;
      half_low.wed_data   <= low_select & is_wed;  // CMD_NONE leaves both low
      half_high.valid     <= high_select;
      half_high.read_data <= high_select & is_read;
      half_high.wed_data  <= high_select & is_wed;
    end
  end

  // Payload zeroed on the idle half
  always_ff @(posedge clock) begin
    half_low.cmd   <= low_select ? lookup_entry : '0;
    half_low.data  <= low_select ? data_latched : '0;
    half_high.cmd  <= high_select ? lookup_entry : '0;
    half_high.data <= high_select ? data_latched : '0;
  end

endmodule

`default_nettype wire

// ==== rtl/read_line_assembler.sv ====
`timescale 1ns/100ps
`default_nettype none

module read_line_assembler (
  input  logic                                       clock,
  input  logic                                       rstn,
  data_control_if.receive                            half_low,
  data_control_if.receive                            half_high,
  output logic                                       line_valid,
  output logic [capi_read_pkg::TAG_BITS-1:0]         line_tag,
  output logic [capi_read_pkg::LINE_BITS-1:0]        line_data,
  output logic                                       wed_valid,
  output logic [capi_read_pkg::ITEM_COUNT_BITS-1:0]  wed_item_count,
  output logic [capi_read_pkg::ADDRESS_BITS-1:0]     wed_source_address,
  output logic [capi_read_pkg::ADDRESS_BITS-1:0]     wed_destination_address
);
  import capi_read_pkg::*;

  logic                low_held;
  logic [TAG_BITS-1:0] low_tag;
  half_line_u          low_data;
  logic                low_read;
  logic                high_read;
  logic                tag_match;
  logic                low_wed;

  assign low_read  = half_low.valid & half_low.read_data;
  assign high_read = half_high.valid & half_high.read_data;
  assign tag_match = low_held & (half_high.cmd.tag == low_tag);
  assign low_wed   = half_low.valid & half_low.wed_data; // High WED halves are dropped

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      low_held   <= 1'b0;
      line_valid <= 1'b0;
      wed_valid  <= 1'b0;
    end else begin
      if (low_read) begin
        low_held <= 1'b1;
      end else if (high_read && tag_match) begin
        low_held <= 1'b0; // Low half consumed
      end
      line_valid <= high_read & tag_match;
      wed_valid  <= low_wed;
    end
  end

  always_ff @(posedge clock) begin
    if (low_read) begin
      low_tag  <= half_low.cmd.tag;
      low_data <= half_low.data;
    end
    if (high_read && tag_match) begin
      line_tag  <= half_high.cmd.tag;
      line_data <= {half_high.data.raw, low_data.raw}; // Low half in lower bits
    end
    if (low_wed) begin
      wed_item_count          <= half_low.data.wed.item_count;
      wed_source_address      <= half_low.data.wed.source_address;
      wed_destination_address <= half_low.data.wed.destination_address;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/read_data_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module read_data_top (
  input  logic                                       clock,
  input  logic                                       rstn,
  input  logic                                       enabled_in,
  input  logic                                       write_valid,
  input  logic [capi_read_pkg::TAG_BITS-1:0]         write_tag,
  input  logic                                       write_tag_parity,
  input  logic                                       write_address,
  input  logic [capi_read_pkg::HALF_LINE_BITS-1:0]   write_data,
  input  logic [capi_read_pkg::DW_COUNT-1:0]         write_parity,
  input  logic                                       issue_valid,
  input  logic [capi_read_pkg::TAG_BITS-1:0]         issue_tag,
  input  capi_read_pkg::cmd_type_t                   issue_type,
  output logic                                       line_valid,
  output logic [capi_read_pkg::TAG_BITS-1:0]         line_tag,
  output logic [capi_read_pkg::LINE_BITS-1:0]        line_data,
  output logic                                       wed_valid,
  output logic [capi_read_pkg::ITEM_COUNT_BITS-1:0]  wed_item_count,
  output logic [capi_read_pkg::ADDRESS_BITS-1:0]     wed_source_address,
  output logic [capi_read_pkg::ADDRESS_BITS-1:0]     wed_destination_address,
  output logic [1:0]                                 data_read_error
);
  import capi_read_pkg::*;

  logic                enabled;    // Registered enable, shared
  logic [TAG_BITS-1:0] lookup_tag;
  tag_entry_t          lookup_entry;

  buffer_write_if buffer ();
  data_control_if half_low ();
  data_control_if half_high ();

  // Plain inputs onto the write bundle
  assign buffer.write_valid      = write_valid;
  assign buffer.write_tag        = write_tag;
  assign buffer.write_tag_parity = write_tag_parity;
  assign buffer.write_address    = write_address;
  assign buffer.write_data       = write_data;
  assign buffer.write_parity     = write_parity;

  command_tag_table command_tag_table_inst (
    .clock        (clock),
    .rstn         (rstn),
    .issue_valid  (issue_valid),
    .issue_tag    (issue_tag),
    .issue_type   (issue_type),
    .lookup_tag   (lookup_tag),
    .lookup_entry (lookup_entry)
  );

  read_data_control read_data_control_inst (
    .clock        (clock),
    .rstn         (rstn),
    .enabled_in   (enabled_in),
    .buffer       (buffer),
    .lookup_tag   (lookup_tag),
    .lookup_entry (lookup_entry),
    .enabled      (enabled),
    .half_low     (half_low),
    .half_high    (half_high)
  );

  buffer_parity_check buffer_parity_check_inst (
    .clock           (clock),
    .rstn            (rstn),
    .enabled         (enabled),
    .buffer          (buffer),
    .data_read_error (data_read_error)
  );

  read_line_assembler read_line_assembler_inst (
    .clock                   (clock),
    .rstn                    (rstn),
    .half_low                (half_low),
    .half_high               (half_high),
    .line_valid              (line_valid),
    .line_tag                (line_tag),
    .line_data               (line_data),
    .wed_valid               (wed_valid),
    .wed_item_count          (wed_item_count),
    .wed_source_address      (wed_source_address),
    .wed_destination_address (wed_destination_address)
  );

endmodule

`default_nettype wire

// ==== verification/read_data_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module read_data_checker (
  input logic       clock,
  input logic       rstn,
  input logic       line_valid,
  input logic       wed_valid,
  input logic [1:0] data_read_error,
  input logic       low_valid,
  input logic       high_valid
);

  // Sampled mid cycle once the reset edge has cleared the flops
  quiet_in_reset: assert property (@(negedge clock) !rstn |->
      !line_valid && !wed_valid && data_read_error == 2'b00 && !low_valid && !high_valid)
    else $error("outputs active while reset is asserted");

  line_wed_exclusive: assert property (@(posedge clock) disable iff (!rstn)
      !(line_valid && wed_valid))
    else $error("line_valid and wed_valid high in the same cycle");

  // One beat per cycle feeds only one half
  halves_exclusive: assert property (@(posedge clock) disable iff (!rstn)
      !(low_valid && high_valid))
    else $error("low and high half outputs valid in the same cycle");

endmodule

bind read_data_top read_data_checker read_data_checker_inst (
  .clock           (clock),
  .rstn            (rstn),
  .line_valid      (line_valid),
  .wed_valid       (wed_valid),
  .data_read_error (data_read_error),
  .low_valid       (half_low.valid),
  .high_valid      (half_high.valid)
);

`default_nettype wire

// ==== verification/read_data_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module read_data_tb;
  import capi_read_pkg::*;

  localparam int MAX_RECORDS = 64;
  localparam int DATA_TOP    = HALF_LINE_BITS - 1;

  logic                       clock;
  logic                       rstn;
  logic                       enabled_in;
  logic                       write_valid;
  logic [TAG_BITS-1:0]        write_tag;
  logic                       write_tag_parity;
  logic                       write_address;
  logic [HALF_LINE_BITS-1:0]  write_data;
  logic [DW_COUNT-1:0]        write_parity;
  logic                       issue_valid;
  logic [TAG_BITS-1:0]        issue_tag;
  cmd_type_t                  issue_type;
  logic                       line_valid;
  logic [TAG_BITS-1:0]        line_tag;
  logic [LINE_BITS-1:0]       line_data;
  logic                       wed_valid;
  logic [ITEM_COUNT_BITS-1:0] wed_item_count;
  logic [ADDRESS_BITS-1:0]    wed_source_address;
  logic [ADDRESS_BITS-1:0]    wed_destination_address;
  logic [1:0]                 data_read_error;

  logic [63:0]                records [MAX_RECORDS];
  int                         record_count;
  int                         cycle_count;
  int                         cycle_limit;
  int                         value_errors;
  int                         pulse_errors;
  int                         seed;

  // Reference model of the tag table and the held low half
  logic                       model_enabled;
  logic [TAG_BITS-1:0]        model_tag [TAG_COUNT];
  cmd_type_t                  model_type [TAG_COUNT];
  logic                       model_low_held;
  logic [TAG_BITS-1:0]        model_low_tag;
  logic [HALF_LINE_BITS-1:0]  model_low_data;

  read_data_top read_data_top_inst (
    .clock                   (clock),
    .rstn                    (rstn),
    .enabled_in              (enabled_in),
    .write_valid             (write_valid),
    .write_tag               (write_tag),
    .write_tag_parity        (write_tag_parity),
    .write_address           (write_address),
    .write_data              (write_data),
    .write_parity            (write_parity),
    .issue_valid             (issue_valid),
    .issue_tag               (issue_tag),
    .issue_type              (issue_type),
    .line_valid              (line_valid),
    .line_tag                (line_tag),
    .line_data               (line_data),
    .wed_valid               (wed_valid),
    .wed_item_count          (wed_item_count),
    .wed_source_address      (wed_source_address),
    .wed_destination_address (wed_destination_address),
    .data_read_error         (data_read_error)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("Run stopped at cycle %0d, the records did not finish in time", cycle_count);
      $display("Something failed");
      $finish;
    end
  end

////////////////////////////////////////////////////////////////////////////
// Checks
////////////////////////////////////////////////////////////////////////////

  task automatic compare_value(input string name, input logic [LINE_BITS-1:0] expected,
                               input logic [LINE_BITS-1:0] actual);
    if (expected !== actual) begin
      value_errors++;
      $display("error %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  task automatic pulse_check(input string name, input logic expected, input logic seen);
    if (expected && !seen) begin
      pulse_errors++;
      $display("%s: the expected pulse did not appear", name);
    end else if (!expected && seen) begin
      pulse_errors++;
      $display("%s: a pulse appeared where none was expected", name);
    end
  endtask

////////////////////////////////////////////////////////////////////////////
// Record handlers
////////////////////////////////////////////////////////////////////////////

  task automatic issue_command(input logic [63:0] rec);
    issue_valid = 1'b1;
    issue_tag   = rec[59:52];
    issue_type  = cmd_type_t'(rec[49:48]);
    @(negedge clock);
    issue_valid = 1'b0;
    model_tag[rec[52 +: TAG_INDEX_BITS]]  = rec[59:52];
    model_type[rec[52 +: TAG_INDEX_BITS]] = cmd_type_t'(rec[49:48]);
  endtask

  task automatic apply_enable(input logic [63:0] rec);
    enabled_in = rec[48];
    repeat (2) @(negedge clock); // Enable is registered in the DUT
    model_enabled = rec[48];
  endtask

  task automatic write_half(input int index, input logic [63:0] rec);
    logic [TAG_BITS-1:0]       tag;
    logic                      address;
    logic [31:0]               base;
    logic [HALF_LINE_BITS-1:0] data;
    logic [DW_COUNT-1:0]       parity;
    cmd_type_t                 kind;
    logic                      expect_line;
    logic                      expect_wed;
    string                     name;
    tag     = rec[59:52];
    address = rec[48];
    base    = rec[47:16];
    name    = $sformatf("write %0d", index);
    for (int j = 0; j < HALF_LINE_BITS / 32; j++) begin
      if (base == 32'h0) begin
        data[j*32 +: 32] = $random(seed);
      end else begin
        data[j*32 +: 32] = base + j * 32'h0101_0101;
      end
    end
    for (int j = 0; j < DW_COUNT; j++) begin
      parity[j] = ~^data[j*DW_BITS +: DW_BITS]; // Odd parity per double word
    end
    if (rec[11:8] != 4'h0) begin
      parity[3] = ~parity[3];
    end
    kind = (model_tag[tag[TAG_INDEX_BITS-1:0]] == tag) ? model_type[tag[TAG_INDEX_BITS-1:0]]
                                                       : CMD_NONE;
    expect_wed  = model_enabled && !address && kind == CMD_WED;
    expect_line = model_enabled && address && kind == CMD_READ && model_low_held &&
                  model_low_tag == tag;
    write_valid      = 1'b1;
    write_tag        = tag;
    write_tag_parity = ~^tag ^ (rec[15:12] != 4'h0);
    write_address    = address;
    write_data       = data;
    write_parity     = parity;
    @(negedge clock);
    write_valid = 1'b0;
    repeat (2) @(negedge clock); // Outputs land three edges after the strobe
    compare_value({name, " error bits"}, LINE_BITS'(rec[5:4]), LINE_BITS'(data_read_error));
    pulse_check({name, " line_valid"}, expect_line, line_valid);
    pulse_check({name, " wed_valid"}, expect_wed, wed_valid);
    if (expect_line && line_valid) begin
      compare_value({name, " line_tag"}, LINE_BITS'(tag), LINE_BITS'(line_tag));
      compare_value({name, " line_data"}, {data, model_low_data}, line_data);
    end
    if (expect_wed && wed_valid) begin
      compare_value({name, " item_count"}, LINE_BITS'(data[DATA_TOP -: 32]),
                    LINE_BITS'(wed_item_count));
      compare_value({name, " source_address"}, LINE_BITS'(data[DATA_TOP-32 -: 64]),
                    LINE_BITS'(wed_source_address));
      compare_value({name, " destination_address"}, LINE_BITS'(data[DATA_TOP-96 -: 64]),
                    LINE_BITS'(wed_destination_address));
    end
    if (model_enabled && kind == CMD_READ) begin
      if (!address) begin
        model_low_held = 1'b1;
        model_low_tag  = tag;
        model_low_data = data;
      end else if (expect_line) begin
        model_low_held = 1'b0;
      end
    end
  endtask

////////////////////////////////////////////////////////////////////////////
// Main sequence
////////////////////////////////////////////////////////////////////////////

  initial begin
    seed             = 14116;
    rstn             = 1'b0;
    enabled_in       = 1'b0;
    write_valid      = 1'b0;
    write_tag        = '0;
    write_tag_parity = 1'b0;
    write_address    = 1'b0;
    write_data       = '0;
    write_parity     = '0;
    issue_valid      = 1'b0;
    issue_tag        = '0;
    issue_type       = CMD_NONE;
    cycle_count      = 0;
    value_errors     = 0;
    pulse_errors     = 0;
    model_enabled    = 1'b0;
    model_low_held   = 1'b0;
    model_low_tag    = '0;
    model_low_data   = '0;
    for (int i = 0; i < TAG_COUNT; i++) begin
      model_tag[i]  = '0;
      model_type[i] = CMD_NONE;
    end
    for (int i = 0; i < MAX_RECORDS; i++) begin
      records[i] = '0;
    end
    $readmemh("verification/read_data_input.txt", records);
    record_count = 0;
    while (record_count < MAX_RECORDS && records[record_count][63:60] != 4'h0) begin
      record_count++;
    end
    cycle_limit = record_count * 8 + 20;

    repeat (4) @(negedge clock);
    rstn = 1'b1;

    for (int i = 0; i < record_count; i++) begin
      case (records[i][63:60])
        4'h1: issue_command(records[i]);
        4'h2: write_half(i, records[i]);
        4'h3: apply_enable(records[i]);
        default: begin
          pulse_errors++;
          $display("Record %0d has an unknown kind and was skipped", i);
        end
      endcase
    end

    $display("Errors: %0d value, %0d pulse", value_errors, pulse_errors);
    if (value_errors == 0 && pulse_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/read_data_input.txt ====
// kind_tag_arg_data_tagcorrupt_datacorrupt_experror_0 (kind 1 issue, 2 write, 3 enable)
// arg is type for issue (1 read, 2 wed), address for write, level for enable; data 0 is random
3_00_1_00000000_0_0_0_0 // enable
1_05_1_00000000_0_0_0_0 // tag 05 read
1_0a_2_00000000_0_0_0_0 // tag 0a wed
2_05_0_00000000_0_0_0_0 // low half
2_05_1_a5a50001_0_0_0_0 // high half, full line
2_0a_0_00000000_0_0_0_0 // wed capture
2_05_0_12345678_1_0_1_0 // low half, tag parity error
2_05_1_00000000_0_1_2_0 // high half, data parity error, full line
2_0a_0_0badf00d_1_1_3_0 // wed with both errors
2_05_1_00000000_0_0_0_0 // high half without low half
2_33_0_00000000_0_0_0_0 // tag never issued
3_00_0_00000000_0_0_0_0 // disable
2_05_0_00000000_1_1_0_0 // ignored while disabled
2_0a_0_00000000_0_0_0_0 // wed ignored while disabled

// ==== read_data_top.f ====
rtl/capi_read_pkg.sv
rtl/buffer_write_if.sv
rtl/data_control_if.sv
rtl/command_tag_table.sv
rtl/buffer_parity_check.sv
rtl/read_data_control.sv
rtl/read_line_assembler.sv
rtl/read_data_top.sv
verification/read_data_checker.sv
verification/read_data_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = read_data_tb
FILELIST  = read_data_top.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_TEXT = Something failed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_TEXT)" $(LOG); then \
	  echo "Simulation FAILED"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
